// ==== dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Datapath word
`define DATA_W 32

// Architectural register file
`define REG_ADDR_W 5
`define NUM_REGS 32

`define CSR_ADDR_W 14

// Sub-operation field forwarded untouched to execute
`define ALU_OP_W 8

`endif

// ==== isa_pkg.sv ====
`include "dispatch_settings.svh"

package isa_pkg;

    // Coarse class of a decoded instruction
    typedef enum logic [2:0] {
        ALU   = 3'd0,
        LOAD  = 3'd1,
        STORE = 3'd2,
        JUMP  = 3'd3,
        CSRRD = 3'd4,
        CSRWR = 3'd5,
        PRIV  = 3'd6
    } op_class_e;

    // Immediate word, or the CSR number held in its low bits
    typedef union packed {
        logic [`DATA_W-1:0] value;
        struct packed {
            logic [`DATA_W-`CSR_ADDR_W-1:0] pad;
            logic [`CSR_ADDR_W-1:0]         addr;
        } csr;
    } imm_word_u;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // Bit 0 is slot 0, bit 1 is slot 1
    typedef logic [1:0] issue_mask_t;

    // Operand source, listed from highest to lowest priority
    typedef enum logic [2:0] {
        EX1 = 3'd0,
        EX0 = 3'd1,
        WB1 = 3'd2,
        WB0 = 3'd3,
        RF  = 3'd4
    } fwd_src_e;

endpackage

// ==== load_scoreboard.sv ====
`include "dispatch_settings.svh"

module load_scoreboard (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  pipe_pkg::issue_mask_t              issue_i,
    input  isa_pkg::op_class_e [1:0]           class_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        rd_i,
    input  logic [1:0]                         wb_we_i,
    input  logic [1:0]                         wb_load_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        wb_addr_i,
    output logic [`NUM_REGS-1:0]               busy_o
);

    logic [`NUM_REGS-1:0] busy_nxt;

    always_comb begin
        busy_nxt = busy_o;
        // Load data returning at writeback
        for (int p = 0; p < 2; p++) begin
            if (wb_we_i[p] && wb_load_i[p]) begin
                busy_nxt[wb_addr_i[p]] = 1'b0;
            end
        end
        // New loads applied last so they win over a same-cycle release
        for (int s = 0; s < 2; s++) begin
            if (issue_i[s] && class_i[s] == isa_pkg::LOAD && rd_i[s] != '0) begin
                busy_nxt[rd_i[s]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= '0;
        end else if (flush_i) begin
            busy_o <= '0;
        end else if (!stall_i) begin
            busy_o <= busy_nxt;
        end
    end

    // r0 is hardwired and must never wait on a load
    a_r0_never_busy: assert property (@(posedge clk) disable iff (!rst_n) !busy_o[0])
        else $error("load_scoreboard: register 0 marked busy");

endmodule

// ==== issue_check.sv ====
`include "dispatch_settings.svh"

module issue_check (
    input  logic [1:0]                         valid_i,
    input  logic                               block_i,
    input  logic [`NUM_REGS-1:0]               busy_i,
    input  isa_pkg::op_class_e [1:0]           class_i,
    input  logic [1:0][1:0]                    rs_valid_i,
    input  logic [1:0][1:0][`REG_ADDR_W-1:0]   rs_addr_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        rd_i,
    input  logic [1:0]                         we_i,
    output pipe_pkg::issue_mask_t              issue_o
);

    logic [1:0]            src_busy;
    logic                  pair_raw;
    logic                  not_alu;
    pipe_pkg::issue_mask_t mask;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_busy[s] = (rs_valid_i[s][0] && busy_i[rs_addr_i[s][0]]) ||
                          (rs_valid_i[s][1] && busy_i[rs_addr_i[s][1]]);
        end
    end

    // Slot 1 consuming the result slot 0 produces in the same pair
    assign pair_raw = we_i[0] && rd_i[0] != '0 &&
                      ((rs_valid_i[1][0] && rs_addr_i[1][0] == rd_i[0]) ||
                       (rs_valid_i[1][1] && rs_addr_i[1][1] == rd_i[0]));

    // Memory, jump, CSR and privileged classes go down alone
    assign not_alu = class_i[0] != isa_pkg::ALU || class_i[1] != isa_pkg::ALU;

    always_comb begin
        if (block_i) begin
            mask = 2'b00;
        end else if (src_busy[0]) begin
            mask = 2'b00;
        end else if (src_busy[1]) begin
            mask = 2'b01;
        end else if (pair_raw) begin
            mask = 2'b01;
        end else if (not_alu) begin
            mask = 2'b01;
        end else begin
            mask = 2'b11;
        end
    end

    // Slot 1 only goes along with a valid slot 0
    assign issue_o = {mask[1] & valid_i[1] & valid_i[0], mask[0] & valid_i[0]};

    always_comb begin
        assert (!(issue_o[1] && !issue_o[0]))
            else $error("issue_check: slot 1 issued without slot 0");
    end

endmodule

// ==== operand_forward.sv ====
`include "dispatch_settings.svh"

module operand_forward (
    input  logic                               rs_valid_i,
    input  logic [`REG_ADDR_W-1:0]             rs_addr_i,
    input  logic [`DATA_W-1:0]                 rf_data_i,
    input  logic [1:0]                         ex_we_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        ex_addr_i,
    input  logic [1:0][`DATA_W-1:0]            ex_data_i,
    input  logic [1:0]                         wb_we_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        wb_addr_i,
    input  logic [1:0][`DATA_W-1:0]            wb_data_i,
    output logic [`DATA_W-1:0]                 operand_o
);

    logic                 lookup;
    logic [1:0]           ex_hit;
    logic [1:0]           wb_hit;
    pipe_pkg::fwd_src_e   src;

    // r0 always comes from the register file
    assign lookup = rs_valid_i && rs_addr_i != '0;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            ex_hit[p] = lookup && ex_we_i[p] && ex_addr_i[p] == rs_addr_i;
            wb_hit[p] = lookup && wb_we_i[p] && wb_addr_i[p] == rs_addr_i;
        end
    end

    // Youngest result first
    always_comb begin
        if (ex_hit[1]) begin
            src = pipe_pkg::EX1;
        end else if (ex_hit[0]) begin
            src = pipe_pkg::EX0;
        end else if (wb_hit[1]) begin
            src = pipe_pkg::WB1;
        end else if (wb_hit[0]) begin
            src = pipe_pkg::WB0;
        end else begin
            src = pipe_pkg::RF;
        end
    end

    always_comb begin
        case (src)
            pipe_pkg::EX1: operand_o = ex_data_i[1];
            pipe_pkg::EX0: operand_o = ex_data_i[0];
            pipe_pkg::WB1: operand_o = wb_data_i[1];
            pipe_pkg::WB0: operand_o = wb_data_i[0];
            default:       operand_o = rf_data_i;
        endcase
    end

    always_comb begin
        assert (rs_addr_i != '0 || src == pipe_pkg::RF)
            else $error("operand_forward: r0 taken from a forwarding bus");
    end

endmodule

// ==== dispatch_reg.sv ====
`include "dispatch_settings.svh"

module dispatch_reg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  pipe_pkg::issue_mask_t              issue_i,
    input  isa_pkg::op_class_e [1:0]           class_i,
    input  logic [1:0][`ALU_OP_W-1:0]          aluop_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        rd_i,
    input  logic [1:0]                         we_i,
    input  logic [1:0]                         use_imm_i,
    input  isa_pkg::imm_word_u [1:0]           imm_i,
    input  logic [1:0][`DATA_W-1:0]            op1_i,
    input  logic [1:0][`DATA_W-1:0]            op2_i,
    input  logic [`DATA_W-1:0]                 csr_rdata_i,
    output logic [1:0]                         ex_valid_o,
    output isa_pkg::op_class_e [1:0]           ex_class_o,
    output logic [1:0][`ALU_OP_W-1:0]          ex_aluop_o,
    output logic [1:0][`REG_ADDR_W-1:0]        ex_rd_o,
    output logic [1:0]                         ex_we_o,
    output logic [1:0][`DATA_W-1:0]            ex_op1_o,
    output logic [1:0][`DATA_W-1:0]            ex_op2_o,
    output logic [1:0]                         ex_csr_we_o,
    output logic [1:0][`CSR_ADDR_W-1:0]        ex_csr_addr_o,
    output logic [1:0][`DATA_W-1:0]            ex_csr_data_o
);

    // Control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_o  <= '0;
            ex_we_o     <= '0;
            ex_csr_we_o <= '0;
        end else if (flush_i) begin
            ex_valid_o  <= '0;
            ex_we_o     <= '0;
            ex_csr_we_o <= '0;
        end else if (!stall_i) begin
            for (int s = 0; s < 2; s++) begin
                ex_valid_o[s]  <= issue_i[s];
                ex_we_o[s]     <= issue_i[s] && we_i[s];
                ex_csr_we_o[s] <= issue_i[s] && class_i[s] == isa_pkg::CSRWR;
            end
        end
    end

    // Payload is zeroed for slots that do not go down
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (flush_i || (!stall_i && !issue_i[s])) begin
                ex_class_o[s]    <= isa_pkg::ALU;
                ex_aluop_o[s]    <= '0;
                ex_rd_o[s]       <= '0;
                ex_op1_o[s]      <= '0;
                ex_op2_o[s]      <= '0;
                ex_csr_addr_o[s] <= '0;
                ex_csr_data_o[s] <= '0;
            end else if (!stall_i) begin
                ex_class_o[s]    <= class_i[s];
                ex_aluop_o[s]    <= aluop_i[s];
                ex_rd_o[s]       <= rd_i[s];
                ex_op1_o[s]      <= op1_i[s];
                ex_op2_o[s]      <= use_imm_i[s] ? imm_i[s].value : op2_i[s];
                ex_csr_addr_o[s] <= imm_i[s].csr.addr;
                ex_csr_data_o[s] <= csr_rdata_i;
            end
        end
    end

    // CSR writes are serialized by the issue rule upstream
    a_single_csr_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_csr_we_o[0] && ex_csr_we_o[1]))
        else $error("dispatch_reg: CSR write on both slots");

endmodule

// ==== dispatch_top.sv ====
`include "dispatch_settings.svh"

module dispatch_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  logic                               block_i,
    input  logic [1:0]                         valid_i,
    input  isa_pkg::op_class_e [1:0]           class_i,
    input  logic [1:0][`ALU_OP_W-1:0]          aluop_i,
    input  logic [1:0][1:0]                    rs_valid_i,
    input  logic [1:0][1:0][`REG_ADDR_W-1:0]   rs_addr_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        rd_i,
    input  logic [1:0]                         we_i,
    input  logic [1:0]                         use_imm_i,
    input  isa_pkg::imm_word_u [1:0]           imm_i,
    output logic [1:0][1:0][`REG_ADDR_W-1:0]   rf_addr_o,
    input  logic [1:0][1:0][`DATA_W-1:0]       rf_data_i,
    input  logic [1:0]                         ex_we_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        ex_addr_i,
    input  logic [1:0][`DATA_W-1:0]            ex_data_i,
    input  logic [1:0]                         wb_we_i,
    input  logic [1:0][`REG_ADDR_W-1:0]        wb_addr_i,
    input  logic [1:0][`DATA_W-1:0]            wb_data_i,
    input  logic [1:0]                         wb_load_i,
    output logic [`CSR_ADDR_W-1:0]             csr_raddr_o,
    input  logic [`DATA_W-1:0]                 csr_rdata_i,
    output logic [1:0]                         accept_o,
    output logic [1:0]                         ex_valid_o,
    output isa_pkg::op_class_e [1:0]           ex_class_o,
    output logic [1:0][`ALU_OP_W-1:0]          ex_aluop_o,
    output logic [1:0][`REG_ADDR_W-1:0]        ex_rd_o,
    output logic [1:0]                         ex_we_o,
    output logic [1:0][`DATA_W-1:0]            ex_op1_o,
    output logic [1:0][`DATA_W-1:0]            ex_op2_o,
    output logic [1:0]                         ex_csr_we_o,
    output logic [1:0][`CSR_ADDR_W-1:0]        ex_csr_addr_o,
    output logic [1:0][`DATA_W-1:0]            ex_csr_data_o
);

    pipe_pkg::issue_mask_t           issue;
    logic [`NUM_REGS-1:0]            busy;
    logic [1:0][1:0][`DATA_W-1:0]    operand;
    logic [1:0]                      is_csr;

    assign accept_o  = stall_i ? 2'b00 : issue;
    assign rf_addr_o = rs_addr_i;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            is_csr[s] = class_i[s] == isa_pkg::CSRRD || class_i[s] == isa_pkg::CSRWR;
        end
    end

    // First CSR slot owns the read port
    assign csr_raddr_o = is_csr[0] ? imm_i[0].csr.addr :
                         is_csr[1] ? imm_i[1].csr.addr : '0;

    load_scoreboard u_scoreboard (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .issue_i   (issue),
        .class_i   (class_i),
        .rd_i      (rd_i),
        .wb_we_i   (wb_we_i),
        .wb_load_i (wb_load_i),
        .wb_addr_i (wb_addr_i),
        .busy_o    (busy)
    );

    issue_check u_issue (
        .valid_i    (valid_i),
        .block_i    (block_i),
        .busy_i     (busy),
        .class_i    (class_i),
        .rs_valid_i (rs_valid_i),
        .rs_addr_i  (rs_addr_i),
        .rd_i       (rd_i),
        .we_i       (we_i),
        .issue_o    (issue)
    );

    // One forwarding mux per slot and source operand
    for (genvar s = 0; s < 2; s++) begin : g_slot
        for (genvar k = 0; k < 2; k++) begin : g_opnd
            operand_forward u_fwd (
                .rs_valid_i (rs_valid_i[s][k]),
                .rs_addr_i  (rs_addr_i[s][k]),
                .rf_data_i  (rf_data_i[s][k]),
                .ex_we_i    (ex_we_i),
                .ex_addr_i  (ex_addr_i),
                .ex_data_i  (ex_data_i),
                .wb_we_i    (wb_we_i),
                .wb_addr_i  (wb_addr_i),
                .wb_data_i  (wb_data_i),
                .operand_o  (operand[s][k])
            );
        end
    end

    dispatch_reg u_dispatch_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .issue_i       (issue),
        .class_i       (class_i),
        .aluop_i       (aluop_i),
        .rd_i          (rd_i),
        .we_i          (we_i),
        .use_imm_i     (use_imm_i),
        .imm_i         (imm_i),
        .op1_i         ({operand[1][0], operand[0][0]}),
        .op2_i         ({operand[1][1], operand[0][1]}),
        .csr_rdata_i   (csr_rdata_i),
        .ex_valid_o    (ex_valid_o),
        .ex_class_o    (ex_class_o),
        .ex_aluop_o    (ex_aluop_o),
        .ex_rd_o       (ex_rd_o),
        .ex_we_o       (ex_we_o),
        .ex_op1_o      (ex_op1_o),
        .ex_op2_o      (ex_op2_o),
        .ex_csr_we_o   (ex_csr_we_o),
        .ex_csr_addr_o (ex_csr_addr_o),
        .ex_csr_data_o (ex_csr_data_o)
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// ==== dispatch_tb.sv ====
`include "dispatch_settings.svh"

module dispatch_tb;

    localparam int CLK_PERIOD = 20;
    localparam int TEST_BLOCKS = 6;
    localparam int CYCLES_PER_BLOCK = 50;
    localparam int MARGIN_CYCLES = 100;

    logic clk;
    logic rst_n;
    logic rst_q;
    logic stall_i, flush_i, block_i;
    logic [1:0] valid_i, we_i, use_imm_i, accept_o;
    isa_pkg::op_class_e [1:0] class_i;
    logic [1:0][`ALU_OP_W-1:0] aluop_i;
    logic [1:0][1:0] rs_valid_i;
    logic [1:0][1:0][`REG_ADDR_W-1:0] rs_addr_i, rf_addr_o;
    logic [1:0][`REG_ADDR_W-1:0] rd_i;
    isa_pkg::imm_word_u [1:0] imm_i;
    logic [1:0][1:0][`DATA_W-1:0] rf_data_i;
    logic [1:0] ex_we_i, wb_we_i, wb_load_i;
    logic [1:0][`REG_ADDR_W-1:0] ex_addr_i, wb_addr_i;
    logic [1:0][`DATA_W-1:0] ex_data_i, wb_data_i;
    logic [`CSR_ADDR_W-1:0] csr_raddr_o;
    logic [`DATA_W-1:0] csr_rdata_i;
    logic [1:0] ex_valid_o, ex_we_o, ex_csr_we_o;
    isa_pkg::op_class_e [1:0] ex_class_o;
    logic [1:0][`ALU_OP_W-1:0] ex_aluop_o;
    logic [1:0][`REG_ADDR_W-1:0] ex_rd_o;
    logic [1:0][`DATA_W-1:0] ex_op1_o, ex_op2_o, ex_csr_data_o;
    logic [1:0][`CSR_ADDR_W-1:0] ex_csr_addr_o;

    // Reference model state
    logic [1:0] exp_accept, exp_valid, exp_we, exp_csr_we, src_busy;
    logic pair_dep;
    logic [`NUM_REGS-1:0] exp_busy, busy_next;
    isa_pkg::op_class_e [1:0] exp_class;
    logic [1:0][`ALU_OP_W-1:0] exp_aluop;
    logic [1:0][`REG_ADDR_W-1:0] exp_rd;
    logic [1:0][`DATA_W-1:0] exp_op1, exp_op2, exp_csr_data;
    logic [1:0][`CSR_ADDR_W-1:0] exp_csr_addr;
    logic [`CSR_ADDR_W-1:0] exp_csr_raddr;

    int errors;
    int cycles;
    logic [31:0] rng;
    logic [1:0] acc_seen;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk_o(clk));

    dispatch_top UUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Register file model repeats the address in every byte
    function automatic logic [`DATA_W-1:0] rf_word(input logic [`REG_ADDR_W-1:0] a);
        return {4{3'b000, a}};
    endfunction

    function automatic logic [`DATA_W-1:0] csr_data_of(input logic [`CSR_ADDR_W-1:0] a);
        return 32'hc5a0_0000 | {{(`DATA_W - `CSR_ADDR_W){1'b0}}, a};
    endfunction

    // Lowest priority first, so a younger match overwrites
    function automatic logic [`DATA_W-1:0] fwd_ref(input logic v,
                                                   input logic [`REG_ADDR_W-1:0] a);
        logic [`DATA_W-1:0] r;
        r = rf_word(a);
        if (v && a != 0) begin
            if (wb_we_i[0] && wb_addr_i[0] == a) r = wb_data_i[0];
            if (wb_we_i[1] && wb_addr_i[1] == a) r = wb_data_i[1];
            if (ex_we_i[0] && ex_addr_i[0] == a) r = ex_data_i[0];
            if (ex_we_i[1] && ex_addr_i[1] == a) r = ex_data_i[1];
        end
        return r;
    endfunction

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rf_data_i[0][k] = rf_word(rf_addr_o[0][k]);
            rf_data_i[1][k] = rf_word(rf_addr_o[1][k]);
        end
    end

    assign csr_rdata_i = csr_data_of(csr_raddr_o);

    // Expected accept from the issue rules
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_busy[s] = (rs_valid_i[s][0] && exp_busy[rs_addr_i[s][0]]) ||
                          (rs_valid_i[s][1] && exp_busy[rs_addr_i[s][1]]);
        end
        pair_dep = we_i[0] && rd_i[0] != 0 &&
                   ((rs_valid_i[1][0] && rs_addr_i[1][0] == rd_i[0]) ||
                    (rs_valid_i[1][1] && rs_addr_i[1][1] == rd_i[0]));
        if (block_i || src_busy[0]) begin
            exp_accept = 2'b00;
        end else if (src_busy[1] || pair_dep || class_i[0] != isa_pkg::ALU ||
                     class_i[1] != isa_pkg::ALU) begin
            exp_accept = 2'b01;
        end else begin
            exp_accept = 2'b11;
        end
        exp_accept[0] = exp_accept[0] && valid_i[0] && !stall_i;
        exp_accept[1] = exp_accept[1] && valid_i[1] && exp_accept[0];
    end

    always_comb begin
        busy_next = exp_busy;
        for (int p = 0; p < 2; p++) begin
            if (wb_we_i[p] && wb_load_i[p]) busy_next[wb_addr_i[p]] = 1'b0;
        end
        for (int s = 0; s < 2; s++) begin
            if (exp_accept[s] && class_i[s] == isa_pkg::LOAD && rd_i[s] != 0) begin
                busy_next[rd_i[s]] = 1'b1;
            end
        end
        exp_csr_raddr = '0;
        if (class_i[0] inside {isa_pkg::CSRRD, isa_pkg::CSRWR}) begin
            exp_csr_raddr = imm_i[0].value[`CSR_ADDR_W-1:0];
        end else if (class_i[1] inside {isa_pkg::CSRRD, isa_pkg::CSRWR}) begin
            exp_csr_raddr = imm_i[1].value[`CSR_ADDR_W-1:0];
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_q <= 1'b0;
            exp_valid <= '0;
            exp_we <= '0;
            exp_csr_we <= '0;
            exp_busy <= '0;
        end else if (flush_i) begin
            rst_q <= 1'b1;
            exp_valid <= '0;
            exp_we <= '0;
            exp_csr_we <= '0;
            exp_busy <= '0;
        end else begin
            rst_q <= 1'b1;
            if (!stall_i) begin
                exp_busy <= busy_next;
                for (int s = 0; s < 2; s++) begin
                    exp_valid[s] <= exp_accept[s];
                    exp_we[s] <= exp_accept[s] && we_i[s];
                    exp_csr_we[s] <= exp_accept[s] && class_i[s] == isa_pkg::CSRWR;
                    exp_class[s] <= class_i[s];
                    exp_aluop[s] <= aluop_i[s];
                    exp_rd[s] <= rd_i[s];
                    exp_op1[s] <= fwd_ref(rs_valid_i[s][0], rs_addr_i[s][0]);
                    exp_op2[s] <= use_imm_i[s] ? imm_i[s].value :
                                  fwd_ref(rs_valid_i[s][1], rs_addr_i[s][1]);
                    exp_csr_addr[s] <= imm_i[s].value[`CSR_ADDR_W-1:0];
                    exp_csr_data[s] <= csr_data_of(exp_csr_raddr);
                end
            end
        end
    end

    always @(posedge clk) cycles <= cycles + 1;

    a_reset_clear: assert property (@(posedge clk)
        !rst_q |-> (ex_valid_o == 0 && ex_csr_we_o == 0 && ex_we_o == 0))
        else begin
            errors++;
            $display("ERROR %0t: outputs not clear around reset", $time);
        end

    a_accept: assert property (@(posedge clk) disable iff (!rst_n) accept_o == exp_accept)
        else begin
            errors++;
            $display("ERROR %0t: accept_o %b, expected %b", $time,
                     $sampled(accept_o), $sampled(exp_accept));
        end

    a_control: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid_o == exp_valid && ex_we_o == exp_we && ex_csr_we_o == exp_csr_we)
        else begin
            errors++;
            $display("ERROR %0t: valid/we/csr_we %b/%b/%b, expected %b/%b/%b", $time,
                     $sampled(ex_valid_o), $sampled(ex_we_o), $sampled(ex_csr_we_o),
                     $sampled(exp_valid), $sampled(exp_we), $sampled(exp_csr_we));
        end

    for (genvar s = 0; s < 2; s++) begin : g_slot_check
        a_payload: assert property (@(posedge clk) disable iff (!rst_n)
            exp_valid[s] |-> (ex_class_o[s] == exp_class[s] && ex_aluop_o[s] == exp_aluop[s] &&
                              ex_rd_o[s] == exp_rd[s] && ex_op1_o[s] == exp_op1[s] &&
                              ex_op2_o[s] == exp_op2[s] &&
                              ex_csr_addr_o[s] == exp_csr_addr[s] &&
                              ex_csr_data_o[s] == exp_csr_data[s]))
            else begin
                errors++;
                $display("ERROR %0t: slot %0d payload op1 %h/%h op2 %h/%h csr %h/%h", $time, s,
                         $sampled(ex_op1_o[s]), $sampled(exp_op1[s]), $sampled(ex_op2_o[s]),
                         $sampled(exp_op2[s]), $sampled(ex_csr_addr_o[s]),
                         $sampled(exp_csr_addr[s]));
            end
    end

    a_csr_raddr: assert property (@(posedge clk) disable iff (!rst_n)
        csr_raddr_o == exp_csr_raddr)
        else begin
            errors++;
            $display("ERROR %0t: csr_raddr_o %h, expected %h", $time,
                     $sampled(csr_raddr_o), $sampled(exp_csr_raddr));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_i && !flush_i) |=> ($stable(ex_valid_o) && $stable(ex_op1_o) && $stable(ex_op2_o)))
        else begin
            errors++;
            $display("ERROR %0t: outputs changed during stall", $time);
        end

    a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> (ex_valid_o == 0 && ex_csr_we_o == 0))
        else begin
            errors++;
            $display("ERROR %0t: outputs not cleared by flush", $time);
        end

    // Accept is sampled mid-cycle while inputs change just after the edge
    task automatic tick();
        @(negedge clk);
        acc_seen = accept_o;
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        {stall_i, flush_i, block_i} = 3'b000;
        valid_i = '0;
        class_i = {isa_pkg::ALU, isa_pkg::ALU};
        aluop_i = '0;
        rs_valid_i = '0;
        rs_addr_i = '0;
        rd_i = '0;
        we_i = '0;
        use_imm_i = '0;
        imm_i = '0;
        {ex_we_i, wb_we_i, wb_load_i} = '0;
        {ex_addr_i, wb_addr_i} = '0;
        {ex_data_i, wb_data_i} = '0;
    endtask

    task automatic set_slot(input int s, input isa_pkg::op_class_e c,
                            input logic [`REG_ADDR_W-1:0] a, input logic [`REG_ADDR_W-1:0] b,
                            input logic [`REG_ADDR_W-1:0] d);
        rng = xorshift(rng);
        valid_i[s] = 1'b1;
        class_i[s] = c;
        aluop_i[s] = rng[`ALU_OP_W-1:0];
        rs_valid_i[s] = 2'b11;
        rs_addr_i[s][0] = a;
        rs_addr_i[s][1] = b;
        rd_i[s] = d;
        we_i[s] = c inside {isa_pkg::ALU, isa_pkg::LOAD, isa_pkg::CSRRD};
        use_imm_i[s] = 1'b0;
        imm_i[s].value = xorshift(rng ^ 32'h5a5a_5a5a);
    endtask

    task automatic random_alu_slot(input int s);
        logic [31:0] r;
        rng = xorshift(rng);
        r = rng;
        set_slot(s, isa_pkg::ALU, r[4:0], r[9:5], r[14:10]);
        use_imm_i[s] = r[15];
    endtask

    task automatic wait_accept(input int limit);
        int n;
        n = 0;
        acc_seen = 2'b00;
        while (!acc_seen[0] && n < limit) begin
            tick();
            n++;
        end
        if (!acc_seen[0]) begin
            errors++;
            $display("Slot 0 was not accepted within %0d cycles", limit);
        end
    endtask

    initial begin
        #((TEST_BLOCKS * CYCLES_PER_BLOCK + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        errors = 0;
        cycles = 0;
        rng = 32'hd7707c84;
        rst_n = 1'b1;
        clear_inputs();
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        // Random ALU pairs, then block and stall
        for (int i = 0; i < 20; i++) begin
            random_alu_slot(0);
            random_alu_slot(1);
            tick();
        end
        set_slot(0, isa_pkg::ALU, 1, 2, 3);
        set_slot(1, isa_pkg::ALU, 4, 5, 6);
        block_i = 1'b1;
        tick();
        block_i = 1'b0;
        stall_i = 1'b1;
        repeat (3) tick();
        stall_i = 1'b0;
        tick();

        // Pair dependency and class rule
        set_slot(0, isa_pkg::ALU, 1, 2, 5);
        set_slot(1, isa_pkg::ALU, 5, 3, 6);
        tick();
        set_slot(0, isa_pkg::ALU, 1, 2, 0);
        set_slot(1, isa_pkg::ALU, 0, 3, 6);
        tick();
        set_slot(0, isa_pkg::ALU, 1, 2, 5);
        set_slot(1, isa_pkg::LOAD, 4, 0, 7);
        tick();
        set_slot(0, isa_pkg::STORE, 1, 2, 0);
        set_slot(1, isa_pkg::ALU, 3, 4, 8);
        tick();

        // All four buses match, then drop them from the top
        clear_inputs();
        set_slot(0, isa_pkg::ALU, 7, 7, 20);
        set_slot(1, isa_pkg::ALU, 7, 0, 21);
        ex_we_i = 2'b11;
        wb_we_i = 2'b11;
        ex_addr_i = {5'd7, 5'd7};
        wb_addr_i = {5'd7, 5'd7};
        ex_data_i = {32'hee11_0001, 32'hee00_0000};
        wb_data_i = {32'hbb11_0001, 32'hbb00_0000};
        tick();
        ex_we_i[1] = 1'b0;
        tick();
        ex_we_i[0] = 1'b0;
        tick();
        wb_we_i[1] = 1'b0;
        tick();
        wb_we_i[0] = 1'b0;
        tick();
        ex_we_i = 2'b11;
        wb_we_i = 2'b11;
        ex_addr_i = '0;
        wb_addr_i = '0;
        set_slot(0, isa_pkg::ALU, 0, 0, 22);
        tick();

        // Load in flight until released by writeback
        clear_inputs();
        set_slot(0, isa_pkg::LOAD, 1, 0, 9);
        wait_accept(5);
        clear_inputs();
        set_slot(0, isa_pkg::ALU, 9, 2, 10);
        set_slot(1, isa_pkg::ALU, 3, 4, 11);
        repeat (3) tick();
        wb_we_i[1] = 1'b1;
        wb_load_i[1] = 1'b1;
        wb_addr_i[1] = 5'd9;
        wb_data_i[1] = 32'h1d00_0009;
        tick();
        wb_we_i = '0;
        wb_load_i = '0;
        wait_accept(5);

        // Load in flight until released by flush
        clear_inputs();
        set_slot(0, isa_pkg::LOAD, 1, 0, 12);
        wait_accept(5);
        set_slot(0, isa_pkg::ALU, 12, 0, 13);
        repeat (2) tick();
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        wait_accept(5);
        // Flush while an issued slot is in the output register and another is accepted
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;

        // CSR read address and write flag
        clear_inputs();
        set_slot(0, isa_pkg::CSRWR, 2, 0, 0);
        imm_i[0].value = 32'habcd_0123;
        set_slot(1, isa_pkg::ALU, 3, 4, 14);
        tick();
        set_slot(0, isa_pkg::ALU, 3, 4, 15);
        set_slot(1, isa_pkg::CSRRD, 0, 0, 16);
        imm_i[1].value = 32'h0000_12ab;
        tick();
        set_slot(0, isa_pkg::CSRRD, 0, 0, 17);
        imm_i[0].value = 32'h7777_0456;
        set_slot(1, isa_pkg::CSRWR, 5, 0, 0);
        imm_i[1].value = 32'h0000_0789;
        tick();
        clear_inputs();
        repeat (2) tick();

        $display("Summary: %0d cycles checked, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
load_scoreboard.sv
issue_check.sv
operand_forward.sv
dispatch_reg.sv
dispatch_top.sv
tb_clock.sv
dispatch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module dispatch_tb \
    --Mdir obj_dir -o dispatch_sim
./obj_dir/dispatch_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
